// File: src.f
+incdir+verilog
verilog/gba_load_pkg.sv
verilog/download_decoder.sv
verilog/cart_write_fifo.sv
verilog/mem_write_port.sv
verilog/gba_loader_top.sv
sim/gba_loader_assert.sv
sim/gba_loader_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the loader testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module gba_loader_tb \
	-Mdir "$BUILD_DIR" -o gba_loader_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"$BUILD_DIR/gba_loader_sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
	exit 1
fi
exit 0

// File: sim/gba_loader_tb.sv
/*
 * Loader testbench. Seeded random BIOS and cartridge downloads, a memory
 * responder with random latency and a queue model that predicts results.
 */

`timescale 1ns/10ps
`include "gba_load_cfg.svh"

module gba_loader_tb
	import gba_load_pkg::*;
();

	localparam int PERIOD      = 40;
	localparam int TOTAL_BEATS = 128 + 3 * 48 + 120 + 6 * 40 + 2 * 32; // All tests
	localparam int WATCHDOG_NS = TOTAL_BEATS * 40 * PERIOD + 20000;
	localparam int unsigned ROM_INT = `GBA_ROM_START_HW;
	localparam logic [`GBA_MEM_AW-1:0] ROM_START = ROM_INT[`GBA_MEM_AW-1:0];

	logic       clk_sys = 1'b0;
	logic       reset;
	ioctl_t     ioctl;
	logic       mem_ready;
	logic       ioctl_wait;
	bios_wr_t   bios;
	cart_info_t cart_info;
	logic       mem_req;
	mem_wr_t    mem_cmd;

	bios_wr_t    exp_bios [$];                // Model of pending results
	int          exp_due [$];                 // Cycle each BIOS write is due
	mem_wr_t     exp_mem [$];
	logic [15:0] img [$];                     // Image being sent
	int          cyc = 0;
	int          err_cnt = 0, chk_cnt = 0, test_cnt = 0, err_base = 0;
	int          resp_min = 1, resp_max = 8;  // Memory latency in cycles
	logic        wait_prev = 1'b0;            // ioctl_wait as the last edge saw it
	logic        saw_wait = 1'b0;

	gba_loader_top gba_loader_top_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ioctl     (ioctl),
		.mem_ready (mem_ready),
		.ioctl_wait(ioctl_wait),
		.bios      (bios),
		.cart_info (cart_info),
		.mem_req   (mem_req),
		.mem_cmd   (mem_cmd)
	);

	bind gba_loader_top gba_loader_assert gba_loader_assert_i (
		.clk_sys(clk_sys), .reset(reset), .ioctl(ioctl), .ioctl_wait(ioctl_wait),
		.bios(bios), .mem_req(mem_req), .mem_ready(mem_ready)
	);

	always #(PERIOD / 2) clk_sys = ~clk_sys;
	always @(posedge clk_sys) cyc <= cyc + 1;  // Edge count

	// ==========================================================================
	// Compare tasks
	// ==========================================================================
	task automatic record_error(input string msg);
		$display("%s", msg);
		err_cnt++;
	endtask

	task automatic check_bios(input bios_wr_t exp, input bios_wr_t got);
		chk_cnt++;
		if (got.addr !== exp.addr)
			record_error($sformatf("ERR bios.addr exp %h got %h", exp.addr, got.addr));
		if (got.data !== exp.data)
			record_error($sformatf("ERR bios.data exp %h got %h", exp.data, got.data));
	endtask

	task automatic check_mem(input mem_wr_t exp, input mem_wr_t got);
		chk_cnt++;
		if (got.addr !== exp.addr)
			record_error($sformatf("ERR mem_cmd.addr exp %h got %h", exp.addr, got.addr));
		if (got.data !== exp.data)
			record_error($sformatf("ERR mem_cmd.data exp %h got %h", exp.data, got.data));
	endtask

	task automatic check_info(input cart_info_t exp, input cart_info_t got);
		chk_cnt++;
		if (got.flash_1m !== exp.flash_1m)
			record_error($sformatf("ERR cart_info.flash_1m exp %h got %h",
				exp.flash_1m, got.flash_1m));
		if (got.cart_type !== exp.cart_type)
			record_error($sformatf("ERR cart_info.cart_type exp %h got %h",
				exp.cart_type, got.cart_type));
		if (got.last_addr !== exp.last_addr)
			record_error($sformatf("ERR cart_info.last_addr exp %h got %h",
				exp.last_addr, got.last_addr));
	endtask

	// ==========================================================================
	// Monitor and memory responder
	// ==========================================================================
	always @(negedge clk_sys) begin : monitor
		int due;
		wait_prev = ioctl_wait;                 // Sampled by the next edge
		if (ioctl_wait)
			saw_wait = 1'b1;
		if (!reset && bios.wr) begin
			if (exp_bios.size() == 0) begin
				record_error("BIOS write seen with no BIOS pair pending");
			end else begin
				due = exp_due.pop_front();
				if (due != cyc)
					record_error($sformatf("BIOS write at cycle %0d, expected at %0d", cyc, due));
				check_bios(exp_bios.pop_front(), bios);
			end
		end
		if (!reset && mem_req) begin
			if (exp_mem.size() == 0)
				record_error("memory write seen with no cartridge beat pending");
			else
				check_mem(exp_mem.pop_front(), mem_cmd);
		end
	end

	initial begin : responder
		int d;
		mem_ready = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (mem_req) begin
				d = $urandom_range(resp_max, resp_min);
				repeat (d) @(posedge clk_sys);
				#2 mem_ready = 1'b1;                 // One cycle pulse
				@(posedge clk_sys);
				#2 mem_ready = 1'b0;
			end
		end
	end

	// ==========================================================================
	// Image helpers and host driver
	// ==========================================================================
	task automatic fill_image(input int n);
		img.delete();
		repeat (n) img.push_back(16'($urandom));
	endtask

	task automatic put_signature(input int off);
		logic [71:0] sig;
		logic [15:0] w;
		int          j, b;
		sig = `GBA_FLASH1M_SIG;
		for (j = 0; j < 9; j++) begin
			b = off + j;
			w = img[b / 2];
			if (b % 2 == 0) w[7:0] = sig[71 - 8 * j -: 8]; // Low byte first
			else            w[15:8] = sig[71 - 8 * j -: 8];
			img[b / 2] = w;
		end
	endtask

	function automatic logic has_signature();
		logic [7:0]  bytes [$];
		logic [71:0] sig;
		logic        hit, same;
		int          p, j;
		sig = `GBA_FLASH1M_SIG;
		hit = 1'b0;
		for (p = 0; p < img.size(); p++) begin
			bytes.push_back(img[p][7:0]);
			bytes.push_back(img[p][15:8]);
		end
		for (p = 0; p + 9 <= bytes.size(); p++) begin
			same = 1'b1;
			for (j = 0; j < 9; j++)
				if (bytes[p + j] != sig[71 - 8 * j -: 8]) same = 1'b0;
			if (same) hit = 1'b1;
		end
		return hit;
	endfunction

	function automatic logic [7:0] cart_index(input logic [1:0] t);
		return {t, 6'($urandom_range(62, 1))};   // Never zero, never all ones
	endfunction

	// Sends img as one download, writes only when the last edge saw no wait
	task automatic send_image(input logic [7:0] index, input logic [`GBA_IOCTL_AW-1:0] start,
		input int gap_pct);
		logic [`GBA_IOCTL_AW-1:0] a;
		logic [15:0]              even;
		int                       i;
		even = '0;
		@(posedge clk_sys);
		#2;
		ioctl.download = 1'b1;
		ioctl.index    = index;
		ioctl.wr       = 1'b0;
		for (i = 0; i < img.size(); i++) begin
			a = start + `GBA_IOCTL_AW'(2 * i);
			@(posedge clk_sys);
			#2;
			while (wait_prev || (i > 0 && $urandom_range(99, 0) < gap_pct)) begin
				ioctl.wr = 1'b0;
				@(posedge clk_sys);
				#2;
			end
			ioctl.wr   = 1'b1;
			ioctl.addr = a;
			ioctl.data = img[i];
			if (index == 8'h00) begin
				if (!a[1]) begin
					even = img[i];
				end else begin
					exp_bios.push_back('{wr: 1'b1, addr: a[13:2], data: {img[i], even}});
					exp_due.push_back(cyc + 1);
				end
			end else if (index != 8'hFF) begin
				exp_mem.push_back('{addr: `GBA_MEM_AW'(a >> 1) + ROM_START, data: img[i]});
			end
		end
		@(posedge clk_sys);
		#2;
		ioctl.wr       = 1'b0;
		ioctl.download = 1'b0;                  // Address held for last_addr
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic run_cart(input logic [7:0] index, input int gap_pct);
		logic [`GBA_IOCTL_AW-1:0] start;
		cart_info_t               exp;
		start = `GBA_IOCTL_AW'($urandom) & ~`GBA_IOCTL_AW'(1);
		send_image(index, start, gap_pct);
		while (exp_mem.size() != 0)
			@(posedge clk_sys);                   // Drain to memory
		exp.flash_1m  = has_signature();
		exp.cart_type = index[7:6];
		exp.last_addr = start + `GBA_IOCTL_AW'(2 * (img.size() - 1));
		@(negedge clk_sys);
		check_info(exp, cart_info);
	endtask

	task automatic end_test(input string name);
		if (exp_bios.size() != 0)
			record_error($sformatf("%0d BIOS writes never appeared", exp_bios.size()));
		if (exp_mem.size() != 0)
			record_error($sformatf("%0d memory writes never appeared", exp_mem.size()));
		test_cnt++;
		$display("test %-14s %s (%0d errors)", name,
			(err_cnt == err_base) ? "ok" : "failed", err_cnt - err_base);
		err_base = err_cnt;
	endtask

	// ==========================================================================
	// Test sequence
	// ==========================================================================
	initial begin : main
		int          seed, k, off;
		logic [1:0]  t;
		seed  = $urandom(44);
		reset = 1'b1;
		ioctl = '0;
		repeat (2) @(posedge clk_sys);
		#2 reset = 1'b0;

		repeat (10) begin                      // Quiet until a download starts
			@(negedge clk_sys);
			if (ioctl_wait !== 1'b0)
				record_error($sformatf("ERR ioctl_wait exp 0 got %h", ioctl_wait));
			if (mem_req !== 1'b0)
				record_error($sformatf("ERR mem_req exp 0 got %h", mem_req));
		end
		end_test("idle");

		fill_image(128);
		send_image(8'h00, `GBA_IOCTL_AW'($urandom_range(4031, 0)) << 2, 20);
		end_test("bios");

		repeat (3) begin
			fill_image(48);
			run_cart(cart_index(2'($urandom)), 30);
		end
		end_test("cart_writes");

		resp_min = 5;                          // Slow memory, host never idles
		resp_max = 8;
		saw_wait = 1'b0;
		fill_image(120);
		run_cart(cart_index(2'($urandom)), 0);
		if (!saw_wait)
			record_error("ioctl_wait never rose under back-pressure");
		resp_min = 1;
		resp_max = 8;
		end_test("backpressure");

		for (k = 0; k < 6; k++) begin
			fill_image(40);
			off = 2 * $urandom_range(34, 0) + k % 2; // Even and odd alignments
			if (k % 3 != 2)
				put_signature(off);
			run_cart(cart_index(2'($urandom)), 25);
		end
		end_test("flash_sig");

		t = 2'($urandom);
		fill_image(32);
		run_cart(cart_index(t), 10);
		fill_image(32);
		run_cart(cart_index(t + 2'(1 + $urandom_range(2, 0))), 10); // New type
		end_test("cart_info");

		repeat (5) @(posedge clk_sys);
		err_cnt += gba_loader_top_i.gba_loader_assert_i.fail_cnt;
		$display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns, the DUT stopped making progress", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: sim/gba_loader_assert.sv
/*
 * Protocol checks on the loader top. Memory request pulse shape and
 * ordering, BIOS write pulse, host write discipline under wait.
 */

`timescale 1ns/10ps

module gba_loader_assert
	import gba_load_pkg::*;
(
	input logic     clk_sys,
	input logic     reset,
	input ioctl_t   ioctl,
	input logic     ioctl_wait,
	input bios_wr_t bios,
	input logic     mem_req,
	input logic     mem_ready
);

	int   fail_cnt = 0;                       // Read by the testbench at the end
	logic in_flight;                          // Request out, ready not yet seen

	always_ff @(posedge clk_sys) begin
		if (reset)
			in_flight <= 1'b0;
		else if (mem_req)
			in_flight <= 1'b1;
		else if (mem_ready)
			in_flight <= 1'b0;
	end

	a_req_pulse: assert property (@(posedge clk_sys) disable iff (reset) mem_req |=> !mem_req)
		else begin $error("mem_req held longer than one cycle"); fail_cnt++; end

	a_req_order: assert property (@(posedge clk_sys) disable iff (reset) in_flight |-> !mem_req)
		else begin $error("mem_req issued before mem_ready"); fail_cnt++; end

	a_bios_pulse: assert property (@(posedge clk_sys) disable iff (reset) bios.wr |=> !bios.wr)
		else begin $error("bios.wr held longer than one cycle"); fail_cnt++; end

	// Host may only write when wait was low at the edge before
	a_host_wait: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl.wr |-> !$past(ioctl_wait))
		else begin $error("host write while ioctl_wait was high"); fail_cnt++; end

endmodule

// File: verilog/gba_loader_top.sv
/*
 * Loader top. Download decoder feeds the cartridge write FIFO, which the
 * memory write port drains into external memory.
 */

`timescale 1ns/10ps

module gba_loader_top
	import gba_load_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  ioctl_t     ioctl,
	input  logic       mem_ready,
	output logic       ioctl_wait,
	output bios_wr_t   bios,
	output cart_info_t cart_info,
	output logic       mem_req,
	output mem_wr_t    mem_cmd
);

	logic    push;                            // Decoder to FIFO
	mem_wr_t push_data;
	logic    pop;                             // FIFO to write port
	mem_wr_t pop_data;
	logic    empty;

	download_decoder download_decoder_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ioctl     (ioctl),
		.bios      (bios),
		.cart_info (cart_info),
		.push      (push),
		.push_data (push_data)
	);

	cart_write_fifo cart_write_fifo_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.pop_data  (pop_data),
		.empty     (empty),
		.wait_host (ioctl_wait)                  // Back-pressure straight to host
	);

	mem_write_port mem_write_port_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.pop_data  (pop_data),
		.empty     (empty),
		.mem_ready (mem_ready),
		.pop       (pop),
		.mem_req   (mem_req),
		.mem_cmd   (mem_cmd)
	);

endmodule

// File: verilog/mem_write_port.sv
/*
 * Memory write port. Takes one FIFO entry at a time and writes it to
 * external memory with a request pulse, then waits for the ready pulse.
 */

`timescale 1ns/10ps

module mem_write_port
	import gba_load_pkg::*;
(
	input  logic    clk_sys,
	input  logic    reset,
	input  mem_wr_t pop_data,
	input  logic    empty,
	input  logic    mem_ready,
	output logic    pop,
	output logic    mem_req,
	output mem_wr_t mem_cmd
);

	typedef enum logic {
		ST_IDLE,
		ST_BUSY                               // Request out, ready pending
	} state_t;

	state_t state;

	// Head is taken in the same cycle it is captured
	assign pop = (state == ST_IDLE) & ~empty;

	// ======================================================================
	// Handshake FSM
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= ST_IDLE;
			mem_req <= 1'b0;
		end else begin
			mem_req <= 1'b0;                       // One cycle pulse
			case (state)
				ST_IDLE: if (pop) begin
					mem_req <= 1'b1;
					state   <= ST_BUSY;
				end
				ST_BUSY: if (mem_ready)
					state <= ST_IDLE;                 // Next entry may go out now
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Command stays put until the memory answers
	always_ff @(posedge clk_sys) begin
		if (pop)
			mem_cmd <= pop_data;
	end

endmodule

// File: verilog/cart_write_fifo.sv
/*
 * Cartridge write FIFO. Holds memory writes in host order and raises
 * host wait early enough that writes already in flight still fit.
 */

`timescale 1ns/10ps
`include "gba_load_cfg.svh"

module cart_write_fifo
	import gba_load_pkg::*;
(
	input  logic    clk_sys,
	input  logic    reset,
	input  logic    push,
	input  mem_wr_t push_data,
	input  logic    pop,
	output mem_wr_t pop_data,
	output logic    empty,
	output logic    wait_host
);

	localparam int DEPTH = `GBA_FIFO_DEPTH;
	localparam int PW    = $clog2(DEPTH);     // Pointer width for a power of two depth
	localparam int CW    = $clog2(DEPTH + 1);

	mem_wr_t         mem [DEPTH];
	logic [PW-1:0]   wr_ptr, rd_ptr;
	logic [CW-1:0]   count, count_next;
	logic            do_push, do_pop;

	assign do_push = push & (count != CW'(DEPTH)); // Push ignored when full
	assign do_pop  = pop & ~empty;

	always_comb begin
		count_next = count;
		case ({do_push, do_pop})
			2'b10:   count_next = count + 1'b1;
			2'b01:   count_next = count - 1'b1;
			default: count_next = count;           // Both or neither
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			wait_host <= 1'b0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
			count     <= count_next;
			wait_host <= count_next >= CW'(`GBA_FIFO_WAIT_LVL); // Tracks fill level
		end
	end

	always_ff @(posedge clk_sys) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	assign pop_data = mem[rd_ptr];           // Show-ahead head entry
	assign empty    = (count == '0);

endmodule

// File: verilog/download_decoder.sv
/*
 * Download decoder. Classifies host downloads by index, packs BIOS
 * halfwords into word writes, scans cartridge data for the flash signature
 * and pushes cartridge halfwords toward external memory.
 */

`timescale 1ns/10ps
`include "gba_load_cfg.svh"

module download_decoder
	import gba_load_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  ioctl_t     ioctl,
	output bios_wr_t   bios,
	output cart_info_t cart_info,
	output logic       push,
	output mem_wr_t    push_data
);

	localparam int unsigned ROM_START_INT = `GBA_ROM_START_HW;
	localparam logic [`GBA_MEM_AW-1:0] ROM_START = ROM_START_INT[`GBA_MEM_AW-1:0];
	localparam logic [71:0] FLASH_SIG = `GBA_FLASH1M_SIG; // Nine bytes

	logic bios_dl, cart_dl, cart_dl_d;      // Registered download class
	logic cart_start, cart_end, cart_wr;

	logic                       bios_wr;
	logic [`GBA_BIOS_AW-1:0]    bios_addr;
	logic [2*`GBA_IOCTL_DW-1:0] bios_data;

	logic                       flash_1m;
	logic [1:0]                 cart_type;
	logic [`GBA_IOCTL_AW-1:0]   last_addr;

	logic [63:0]                str;        // Last eight image bytes with the newest lowest
	logic [63:0]                hist;       // History as seen by this beat
	logic [`GBA_MEM_AW-1:0]     push_addr;
	logic [`GBA_IOCTL_DW-1:0]   push_dat;

	// ======================================================================
	// Download classification
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bios_dl   <= 1'b0;
			cart_dl   <= 1'b0;
			cart_dl_d <= 1'b0;
		end else begin
			bios_dl   <= ioctl.download & (ioctl.index == 8'd0);
			cart_dl   <= ioctl.download & (|ioctl.index) & ~(&ioctl.index); // All ones is codes
			cart_dl_d <= cart_dl;
		end
	end

	assign cart_start = cart_dl & ~cart_dl_d;
	assign cart_end   = cart_dl_d & ~cart_dl;
	assign cart_wr    = cart_dl & ioctl.wr;

	// ======================================================================
	// BIOS packing
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset)
			bios_wr <= 1'b0;
		else
			bios_wr <= bios_dl & ioctl.wr & ioctl.addr[1]; // Odd halfword closes the word
	end

	always_ff @(posedge clk_sys) begin
		if (bios_dl && ioctl.wr) begin
			if (!ioctl.addr[1]) begin
				bios_data[15:0] <= ioctl.data;      // Held until the odd half
			end else begin
				bios_data[31:16] <= ioctl.data;
				bios_addr        <= ioctl.addr[13:2];
			end
		end
	end

	assign bios = '{wr: bios_wr, addr: bios_addr, data: bios_data};

	// ======================================================================
	// Cartridge info and signature scan
	// ======================================================================
	// A fresh download must not match across the previous image's tail
	always_comb begin
		hist = cart_start ? '0 : str;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			flash_1m  <= 1'b0;
			cart_type <= 2'd0;
			last_addr <= '0;
		end else begin
			if (cart_start) begin
				flash_1m  <= 1'b0;
				cart_type <= ioctl.index[7:6];
			end
			if (cart_end)
				last_addr <= ioctl.addr;         // Host still holds final address
			if (cart_wr) begin
				if ({hist, ioctl.data[7:0]} == FLASH_SIG)
					flash_1m <= 1'b1;                // Ends on low byte
				if ({hist[55:0], ioctl.data[7:0], ioctl.data[15:8]} == FLASH_SIG)
					flash_1m <= 1'b1;                // Ends on high byte
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_wr)
			str <= {hist[47:0], ioctl.data[7:0], ioctl.data[15:8]};
		else if (cart_start)
			str <= '0;                           // First beat may come later
	end

	assign cart_info = '{flash_1m: flash_1m, cart_type: cart_type, last_addr: last_addr};

	// ======================================================================
	// Cartridge memory writes
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset)
			push <= 1'b0;
		else
			push <= cart_wr;                      // One cycle behind host write
	end

	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			push_addr <= ioctl.addr[`GBA_IOCTL_AW-1:1] + ROM_START; // Byte to halfword
			push_dat  <= ioctl.data;
		end
	end

	assign push_data = '{addr: push_addr, data: push_dat};

endmodule

// File: verilog/gba_load_pkg.sv
/*
 * Shared types for the download front end.
 * Host beat, BIOS RAM write, cartridge info and external memory write.
 */

`include "gba_load_cfg.svh"

package gba_load_pkg;

	// One beat of the host download stream
	typedef struct packed {
		logic                       download;  // Download in progress
		logic [7:0]                 index;     // File slot, top bits carry cart type
		logic [`GBA_IOCTL_AW-1:0]   addr;      // Byte address
		logic [`GBA_IOCTL_DW-1:0]   data;      // Low byte comes first in the image
		logic                       wr;        // Write strobe
	} ioctl_t;

	// BIOS RAM write, two host halfwords packed into one word
	typedef struct packed {
		logic                       wr;
		logic [`GBA_BIOS_AW-1:0]    addr;
		logic [2*`GBA_IOCTL_DW-1:0] data;      // Odd halfword on top
	} bios_wr_t;

	// Facts learned about the cartridge while it streams in
	typedef struct packed {
		logic                       flash_1m;  // Signature seen in the image
		logic [1:0]                 cart_type; // From index bits 7:6
		logic [`GBA_IOCTL_AW-1:0]   last_addr; // Address of final beat
	} cart_info_t;

	// Pending external memory write
	typedef struct packed {
		logic [`GBA_MEM_AW-1:0]     addr;      // Halfword address
		logic [`GBA_IOCTL_DW-1:0]   data;
	} mem_wr_t;

endpackage

// File: verilog/gba_load_cfg.svh
/*
 * Loader configuration for the cartridge and BIOS download front end.
 * Bus widths, ROM placement in external memory, FIFO sizing, flash signature.
 */

`ifndef GBA_LOAD_CFG_SVH
`define GBA_LOAD_CFG_SVH

// ==========================================================================
// Host download bus
// ==========================================================================
`define GBA_IOCTL_AW      27               // Host byte address
`define GBA_IOCTL_DW      16               // Host data word

// ==========================================================================
// Targets
// ==========================================================================
`define GBA_BIOS_AW       12               // BIOS RAM 32-bit word address
`define GBA_MEM_AW        26               // External memory halfword address
`define GBA_ROM_START_HW  393216           // ROM region, halfword units

// Cartridge write buffering
`define GBA_FIFO_DEPTH    8
`define GBA_FIFO_WAIT_LVL (`GBA_FIFO_DEPTH - 2) // Leaves room for in-flight writes

// Save type marker searched for in the cartridge image
`define GBA_FLASH1M_SIG   "FLASH1M_V"

`endif
